// File: files.f
cpu_pkg.sv
instr_decoder.sv
reg_file.sv
alu_shift.sv
datapath.sv
fetch_unit.sv
control_fsm.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# build the cpu testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f files.f -o sim_cpu \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log
grep -qx "Test completed successfully" sim.log && echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

// File: tb_cpu.sv
// cpu testbench
`timescale 1ns/10ps

module tb_cpu;
	localparam int max_rows = 24;
	localparam int max_words = 12;
	localparam logic [15:0] halt_word = 16'hE000;

	logic clk, reset, halt;
	logic [15:0] read_data, datapath_out;
	logic [8:0] mem_addr;
	cpu_pkg::mem_cmd_t mem_cmd;
	logic [15:0] mem [512];

	string name_tab [max_rows];
	logic [15:0] prog_tab [max_rows][max_words];
	int len_tab [max_rows];
	logic [15:0] preset_tab [max_rows];
	int addr_tab [max_rows];
	logic [15:0] expect_tab [max_rows];
	int rows, run_count, errors, passed, seed;
	bit timed_out;

	cpu #(.addr_width(9)) dut_i (.clk(clk), .reset(reset), .read_data(read_data),
		.mem_cmd(mem_cmd), .mem_addr(mem_addr), .datapath_out(datapath_out), .halt(halt));

	always #4 clk = ~clk;

	assign read_data = mem[mem_addr]; // same cycle answer

	always @(posedge clk) begin
		if (mem_cmd == cpu_pkg::mem_write) mem[mem_addr] <= datapath_out;
	end

	function automatic logic [15:0] sign_ext8(input logic [7:0] x);
		return {{8{x[7]}}, x};
	endfunction

	function automatic logic [15:0] shifted(input logic [15:0] x, input int sh);
		case (sh)
			1: return x << 1;
			2: return x >> 1;
			3: return 16'($signed(x) >>> 1); // sign fills in
			default: return x;
		endcase
	endfunction

	// lt and le follow the signed order of the cmp operands
	function automatic bit branch_taken(input int cond, input logic [15:0] a, input logic [15:0] b);
		case (cond)
			0: return 1'b1;
			1: return a == b;
			2: return a != b;
			3: return $signed(a) < $signed(b);
			default: return $signed(a) <= $signed(b);
		endcase
	endfunction

	function automatic logic [15:0] mov_imm(input int rn, input logic [7:0] imm);
		return {3'b110, 2'b10, 3'(rn), imm};
	endfunction

	function automatic logic [15:0] alu_instr(input int op, rn, rd, sh, rm);
		return {3'b101, 2'(op), 3'(rn), 3'(rd), 2'(sh), 3'(rm)};
	endfunction

	function automatic logic [15:0] mov_shift(input int rd, sh, rm);
		return {3'b110, 2'b00, 3'b000, 3'(rd), 2'(sh), 3'(rm)};
	endfunction

	function automatic logic [15:0] mem_instr(input logic [2:0] opc, input int rd, rn, imm5);
		return {opc, 2'b00, 3'(rn), 3'(rd), 5'(imm5)};
	endfunction

	function automatic logic [15:0] branch_instr(input int cond, input logic [7:0] offset);
		return {3'b001, 2'b00, 3'(cond), offset};
	endfunction

	task automatic new_row(input string nm, input logic [15:0] pre, input int addr,
		input logic [15:0] exp);
		name_tab[rows] = nm;
		preset_tab[rows] = pre;
		addr_tab[rows] = addr;
		expect_tab[rows] = exp;
		len_tab[rows] = 0;
		rows++;
	endtask

	task automatic emit(input logic [15:0] w);
		prog_tab[rows-1][len_tab[rows-1]] = w;
		len_tab[rows-1]++;
	endtask

	// r3 goes to address 104
	task automatic store_and_halt();
		emit(mov_imm(7, 8'd100));
		emit(mem_instr(3'b100, 3, 7, 4));
		emit(halt_word);
	endtask

	task automatic build_table();
		logic [7:0] a, b, addend;
		logic [15:0] pre;
		logic [7:0] xs [3];
		logic [7:0] ys [3];
		string pair_names [3];
		string cond_names [5];
		int r;
		xs = '{8'd3, 8'hF9, 8'd50}; // equal, less, greater pairs
		ys = '{8'd3, 8'd20, 8'hC4};
		pair_names = '{"equal", "less", "greater"};
		cond_names = '{"al", "eq", "ne", "lt", "le"};
		rows = 0;
		new_row("mov_imm_neg", 16'h0000, 104, 16'hFFA5);
		emit(mov_imm(1, 8'hA5));
		emit(mov_imm(7, 8'd100));
		emit(mem_instr(3'b100, 1, 7, 4));
		emit(halt_word);
		for (int sh = 0; sh < 4; sh++) begin
			r = $random(seed);
			a = r[7:0];
			r = $random(seed);
			b = r[7:0];
			new_row($sformatf("add_shift%0d", sh), 16'h0000, 104,
				sign_ext8(a) + shifted(sign_ext8(b), sh));
			emit(mov_imm(1, a));
			emit(mov_imm(2, b));
			emit(alu_instr(0, 1, 3, sh, 2));
			store_and_halt();
		end
		r = $random(seed);
		a = r[7:0];
		r = $random(seed);
		b = r[7:0] | 8'h80; // negative so lsr and asr differ
		new_row("and_lsl", 16'h0000, 104, sign_ext8(a) & shifted(sign_ext8(b), 1));
		emit(mov_imm(1, a));
		emit(mov_imm(2, b));
		emit(alu_instr(2, 1, 3, 1, 2));
		store_and_halt();
		new_row("mvn_lsr", 16'h0000, 104, ~shifted(sign_ext8(b), 2));
		emit(mov_imm(2, b));
		emit(alu_instr(3, 0, 3, 2, 2));
		store_and_halt();
		new_row("mov_asr", 16'h0000, 104, shifted(sign_ext8(b), 3));
		emit(mov_imm(2, b));
		emit(mov_shift(3, 3, 2));
		store_and_halt();
		r = $random(seed);
		pre = r[15:0];
		r = $random(seed);
		addend = r[7:0];
		new_row("ldr_add", pre, 102, pre + sign_ext8(addend));
		emit(mov_imm(7, 8'd98));
		emit(mem_instr(3'b011, 1, 7, 2)); // 98 + 2 is the preset word
		emit(mov_imm(2, addend));
		emit(alu_instr(0, 1, 3, 0, 2));
		emit(mem_instr(3'b100, 3, 7, 4));
		emit(halt_word);
		for (int c = 0; c < 5; c++) begin
			for (int p = 0; p < 3; p++) begin
				new_row($sformatf("br_%s_%s", cond_names[c], pair_names[p]), 16'h1234, 100,
					branch_taken(c, sign_ext8(xs[p]), sign_ext8(ys[p])) ? 16'h003C : 16'h1234);
				emit(mov_imm(1, xs[p]));
				emit(mov_imm(2, ys[p]));
				emit(mov_imm(7, 8'd100));
				emit(mov_imm(4, 8'h3C)); // marker
				emit(alu_instr(1, 1, 0, 0, 2));
				emit(branch_instr(c, 8'd1)); // taken skips the first halt
				emit(halt_word);
				emit(mem_instr(3'b100, 4, 7, 0));
				emit(halt_word);
			end
		end
	endtask

	task automatic load_memory(input int t);
		for (int i = 0; i < 512; i++) begin
			mem[i] <= 16'(i) ^ 16'hC3A5;
		end
		mem[100] <= preset_tab[t];
		for (int j = 0; j < len_tab[t]; j++) begin
			mem[j] <= prog_tab[t][j];
		end
	endtask

	task automatic run_test(input int t);
		int cycles, limit, errors_before;
		logic [15:0] got;
		errors_before = errors;
		limit = 12 * len_tab[t] + 10; // longest instruction is ten cycles
		@(posedge clk);
		#1;
		reset = 1'b1;
		load_memory(t);
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		if (mem_cmd !== cpu_pkg::mem_none) begin
			$display("FAIL %0t mem_cmd expected %0d got %0d", $time, cpu_pkg::mem_none, mem_cmd);
			errors++;
		end
		if (halt !== 1'b0) begin
			$display("FAIL %0t halt expected 0 got %b", $time, halt);
			errors++;
		end
		cycles = 0;
		while (halt !== 1'b1 && cycles < limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (halt !== 1'b1) begin
			$display("timeout: %s did not halt within %0d cycles", name_tab[t], limit);
			timed_out = 1'b1;
			errors++;
		end else begin
			got = mem[addr_tab[t]];
			if (got !== expect_tab[t]) begin
				$display("FAIL %0t mem[%0d] expected %h got %h", $time, addr_tab[t],
					expect_tab[t], got);
				errors++;
			end
			repeat (20) begin
				@(posedge clk);
				#1;
				if (halt !== 1'b1) begin
					$display("FAIL %0t halt expected 1 got %b", $time, halt);
					errors++;
				end
				if (mem_cmd == cpu_pkg::mem_write) begin
					$display("memory write seen after halt at %0t", $time);
					errors++;
				end
			end
		end
		run_count++;
		if (errors == errors_before) begin
			passed++;
			$display("test %s passed", name_tab[t]);
		end else begin
			$display("test %s failed", name_tab[t]);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		seed = 63;
		errors = 0;
		passed = 0;
		run_count = 0;
		timed_out = 1'b0;
		build_table();
		for (int t = 0; t < rows && !timed_out; t++) begin
			run_test(t);
		end
		$display("tests run %0d of %0d, passed %0d, failed %0d", run_count, rows, passed,
			run_count - passed);
		if (errors == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

// File: cpu.sv
// multi-cycle risc cpu top
`timescale 1ns/10ps

module cpu #(
	parameter int addr_width = 9
) (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::word_width-1:0] read_data,
	output cpu_pkg::mem_cmd_t mem_cmd,
	output logic [addr_width-1:0] mem_addr,
	output logic [cpu_pkg::word_width-1:0] datapath_out,
	output logic halt
);
	logic [cpu_pkg::word_width-1:0] instr, sximm5, sximm8;
	logic [cpu_pkg::reg_sel_width-1:0] reg_num;
	logic [2:0] opcode, cond;
	logic [1:0] op;
	cpu_pkg::shift_t shift;
	cpu_pkg::nsel_t nsel;
	cpu_pkg::wb_src_t vsel;
	cpu_pkg::alu_op_t alu_op;
	logic loada, loadb, loadc, loads, asel, bsel, write;
	logic load_ir, load_pc, reset_pc, branch_take, addr_sel, load_addr;
	logic z, n, v;

	fetch_unit #(.addr_width(addr_width)) fetch_i (.clk(clk), .reset_pc(reset_pc),
		.load_pc(load_pc), .load_ir(load_ir), .load_addr(load_addr), .branch_take(branch_take),
		.addr_sel(addr_sel), .read_data(read_data), .sximm8(sximm8), .c_out(datapath_out),
		.instr(instr), .mem_addr(mem_addr));

	instr_decoder dec_i (.instr(instr), .nsel(nsel), .opcode(opcode), .cond(cond), .op(op),
		.shift(shift), .sximm5(sximm5), .sximm8(sximm8), .reg_num(reg_num));

	datapath dp_i (.clk(clk), .loada(loada), .loadb(loadb), .loadc(loadc), .loads(loads),
		.asel(asel), .bsel(bsel), .write(write), .vsel(vsel), .reg_num(reg_num),
		.shift(shift), .alu_op(alu_op), .read_data(read_data), .sximm8(sximm8),
		.sximm5(sximm5), .z(z), .n(n), .v(v), .c_out(datapath_out));

	control_fsm fsm_i (.clk(clk), .reset(reset), .opcode(opcode), .op(op), .cond(cond),
		.z(z), .n(n), .v(v), .loada(loada), .loadb(loadb), .loadc(loadc), .loads(loads),
		.asel(asel), .bsel(bsel), .write(write), .vsel(vsel), .nsel(nsel), .alu_op(alu_op),
		.load_ir(load_ir), .load_pc(load_pc), .reset_pc(reset_pc), .branch_take(branch_take),
		.addr_sel(addr_sel), .load_addr(load_addr), .mem_cmd(mem_cmd), .halt(halt));
endmodule

// File: control_fsm.sv
// controller state machine
`timescale 1ns/10ps

module control_fsm (
	input logic clk,
	input logic reset,
	input logic [2:0] opcode,
	input logic [1:0] op,
	input logic [2:0] cond,
	input logic z,
	input logic n,
	input logic v,
	output logic loada,
	output logic loadb,
	output logic loadc,
	output logic loads,
	output logic asel,
	output logic bsel,
	output logic write,
	output cpu_pkg::wb_src_t vsel,
	output cpu_pkg::nsel_t nsel,
	output cpu_pkg::alu_op_t alu_op,
	output logic load_ir,
	output logic load_pc,
	output logic reset_pc,
	output logic branch_take,
	output logic addr_sel,
	output logic load_addr,
	output cpu_pkg::mem_cmd_t mem_cmd,
	output logic halt
);
	cpu_pkg::state_t state, next_state;
	logic cond_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::reset_st;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (cond)
			cpu_pkg::cond_al: cond_ok = 1'b1;
			cpu_pkg::cond_eq: cond_ok = z;
			cpu_pkg::cond_ne: cond_ok = !z;
			cpu_pkg::cond_lt: cond_ok = n ^ v;
			cpu_pkg::cond_le: cond_ok = (n ^ v) | z;
			default: cond_ok = 1'b0;
		endcase
	end

	always_comb begin
		next_state = cpu_pkg::halt_st; // undefined opcodes park here
		case (state)
			cpu_pkg::reset_st: next_state = cpu_pkg::fetch1;
			cpu_pkg::fetch1: next_state = cpu_pkg::fetch2;
			cpu_pkg::fetch2: next_state = cpu_pkg::update_pc;
			cpu_pkg::update_pc: next_state = cpu_pkg::decode_st;
			cpu_pkg::decode_st: begin
				case ({opcode, op})
					{cpu_pkg::opc_mov, 2'b10}: next_state = cpu_pkg::movi_s1;
					{cpu_pkg::opc_mov, 2'b00}: next_state = cpu_pkg::movs_s1;
					{cpu_pkg::opc_alu, 2'b00}: next_state = cpu_pkg::add_s1;
					{cpu_pkg::opc_alu, 2'b01}: next_state = cpu_pkg::cmp_s1;
					{cpu_pkg::opc_alu, 2'b10}: next_state = cpu_pkg::add_s1; // and
					{cpu_pkg::opc_alu, 2'b11}: next_state = cpu_pkg::movs_s1; // mvn
					{cpu_pkg::opc_ldr, 2'b00}: next_state = cpu_pkg::ldr_s1;
					{cpu_pkg::opc_str, 2'b00}: next_state = cpu_pkg::str_s1;
					{cpu_pkg::opc_branch, 2'b00}: next_state = cpu_pkg::branch_s1;
					{cpu_pkg::opc_halt, 2'b00}: next_state = cpu_pkg::halt_st;
					default: next_state = cpu_pkg::halt_st;
				endcase
			end
			// steps inside one instruction are consecutive in the enum
			cpu_pkg::movs_s1, cpu_pkg::movs_s2,
			cpu_pkg::add_s1, cpu_pkg::add_s2, cpu_pkg::add_s3,
			cpu_pkg::cmp_s1, cpu_pkg::cmp_s2,
			cpu_pkg::ldr_s1, cpu_pkg::ldr_s2, cpu_pkg::ldr_s3, cpu_pkg::ldr_s4,
			cpu_pkg::str_s1, cpu_pkg::str_s2, cpu_pkg::str_s3, cpu_pkg::str_s4, cpu_pkg::str_s5:
				next_state = cpu_pkg::state_t'(state + 5'd1);
			cpu_pkg::movi_s1, cpu_pkg::movs_s3, cpu_pkg::add_s4, cpu_pkg::cmp_s3,
			cpu_pkg::ldr_s5, cpu_pkg::str_s6, cpu_pkg::branch_s1:
				next_state = cpu_pkg::fetch1;
			default: next_state = cpu_pkg::halt_st;
		endcase
	end

	always_comb begin
		loada = 1'b0;
		loadb = 1'b0;
		loadc = 1'b0;
		loads = 1'b0;
		asel = 1'b0;
		bsel = 1'b0;
		write = 1'b0;
		vsel = cpu_pkg::from_c;
		nsel = cpu_pkg::pick_rm;
		alu_op = cpu_pkg::alu_op_t'(op); // op field selects the alu function
		load_ir = 1'b0;
		load_pc = 1'b0;
		reset_pc = 1'b0;
		branch_take = 1'b0;
		addr_sel = 1'b0;
		load_addr = 1'b0;
		mem_cmd = cpu_pkg::mem_none;
		case (state)
			cpu_pkg::reset_st: begin
				load_pc = 1'b1;
				reset_pc = 1'b1;
			end
			cpu_pkg::fetch1: begin
				mem_cmd = cpu_pkg::mem_read;
				addr_sel = 1'b1;
			end
			cpu_pkg::fetch2: begin
				mem_cmd = cpu_pkg::mem_read;
				addr_sel = 1'b1;
				load_ir = 1'b1;
			end
			cpu_pkg::update_pc: load_pc = 1'b1;
			cpu_pkg::movi_s1: begin
				nsel = cpu_pkg::pick_rn;
				vsel = cpu_pkg::from_imm8;
				write = 1'b1;
			end
			cpu_pkg::movs_s1, cpu_pkg::add_s2, cpu_pkg::cmp_s2: begin
				nsel = cpu_pkg::pick_rm;
				loadb = 1'b1;
			end
			cpu_pkg::movs_s2: begin
				asel = 1'b1;
				loadc = 1'b1;
			end
			cpu_pkg::movs_s3, cpu_pkg::add_s4: begin
				nsel = cpu_pkg::pick_rd;
				write = 1'b1;
			end
			cpu_pkg::add_s1, cpu_pkg::cmp_s1, cpu_pkg::ldr_s1, cpu_pkg::str_s1: begin
				nsel = cpu_pkg::pick_rn;
				loada = 1'b1;
			end
			cpu_pkg::add_s3: loadc = 1'b1;
			cpu_pkg::cmp_s3: loads = 1'b1;
			cpu_pkg::ldr_s2, cpu_pkg::str_s2: begin
				bsel = 1'b1; // rn + sximm5
				alu_op = cpu_pkg::alu_add;
				loadc = 1'b1;
			end
			cpu_pkg::ldr_s3: load_addr = 1'b1;
			cpu_pkg::ldr_s4: mem_cmd = cpu_pkg::mem_read;
			cpu_pkg::ldr_s5: begin
				mem_cmd = cpu_pkg::mem_read;
				nsel = cpu_pkg::pick_rd;
				vsel = cpu_pkg::from_mem;
				write = 1'b1;
			end
			cpu_pkg::str_s3: begin
				load_addr = 1'b1;
				nsel = cpu_pkg::pick_rd; // store data into b
				loadb = 1'b1;
			end
			cpu_pkg::str_s4: begin
				asel = 1'b1;
				alu_op = cpu_pkg::alu_add;
				loadc = 1'b1;
			end
			cpu_pkg::str_s5, cpu_pkg::str_s6: mem_cmd = cpu_pkg::mem_write;
			cpu_pkg::branch_s1: begin
				branch_take = cond_ok;
				load_pc = cond_ok;
			end
			default: ;
		endcase
	end

	assign halt = (state == cpu_pkg::halt_st);

	// a write only ever comes from a decoded store instruction
	a_write_only_in_str: assert property (@(posedge clk) disable iff (reset)
		(mem_cmd == cpu_pkg::mem_write) |-> (opcode == cpu_pkg::opc_str) && (op == 2'b00))
		else $error("memory write outside store");
	// the pc has been on the bus for a full cycle before the ir loads
	a_ir_after_fetch1: assert property (@(posedge clk) disable iff (reset)
		load_ir |-> ($past(state) == cpu_pkg::fetch1) && $past(addr_sel))
		else $error("instruction register loaded outside fetch");
endmodule

// File: fetch_unit.sv
// instruction register, pc and data address
`timescale 1ns/10ps

module fetch_unit #(
	parameter int addr_width = 9
) (
	input logic clk,
	input logic reset_pc,
	input logic load_pc,
	input logic load_ir,
	input logic load_addr,
	input logic branch_take,
	input logic addr_sel,
	input logic [cpu_pkg::word_width-1:0] read_data,
	input logic [cpu_pkg::word_width-1:0] sximm8,
	input logic [cpu_pkg::word_width-1:0] c_out,
	output logic [cpu_pkg::word_width-1:0] instr,
	output logic [addr_width-1:0] mem_addr
);
	logic [addr_width-1:0] pc, next_pc, data_addr;

	// pc already points past the branch when the offset is added
	always_comb begin
		if (reset_pc) next_pc = '0;
		else if (branch_take) next_pc = pc + sximm8[addr_width-1:0];
		else next_pc = pc + addr_width'(1);
	end

	always_ff @(posedge clk) begin
		if (load_ir) instr <= read_data;
		if (load_pc) pc <= next_pc;
		if (load_addr) data_addr <= c_out[addr_width-1:0]; // computed ldr/str address
	end

	assign mem_addr = addr_sel ? pc : data_addr;

	a_pc_src_onehot: assert property (@(posedge clk) !(reset_pc && branch_take))
		else $error("pc reset and branch requested together");
endmodule

// File: datapath.sv
// register file, operand registers and alu
`timescale 1ns/10ps

module datapath (
	input logic clk,
	input logic loada,
	input logic loadb,
	input logic loadc,
	input logic loads,
	input logic asel,
	input logic bsel,
	input logic write,
	input cpu_pkg::wb_src_t vsel,
	input logic [cpu_pkg::reg_sel_width-1:0] reg_num,
	input cpu_pkg::shift_t shift,
	input cpu_pkg::alu_op_t alu_op,
	input logic [cpu_pkg::word_width-1:0] read_data,
	input logic [cpu_pkg::word_width-1:0] sximm8,
	input logic [cpu_pkg::word_width-1:0] sximm5,
	output logic z,
	output logic n,
	output logic v,
	output logic [cpu_pkg::word_width-1:0] c_out
);
	logic [cpu_pkg::word_width-1:0] wb_data, rf_out;
	logic [cpu_pkg::word_width-1:0] a_reg, b_reg, a_in, b_in, alu_out;
	logic alu_z, alu_n, alu_v;

	always_comb begin
		case (vsel)
			cpu_pkg::from_imm8: wb_data = sximm8;
			cpu_pkg::from_mem: wb_data = read_data;
			default: wb_data = c_out;
		endcase
	end

	reg_file rf_i (.clk(clk), .write(write), .reg_num(reg_num), .data_in(wb_data),
		.data_out(rf_out));

	always_ff @(posedge clk) begin
		if (loada) a_reg <= rf_out;
		if (loadb) b_reg <= rf_out;
		if (loadc) c_out <= alu_out;
		if (loads) begin
			z <= alu_z;
			n <= alu_n;
			v <= alu_v;
		end
	end

	assign a_in = asel ? '0 : a_reg; // zero for mov, mvn and store data
	assign b_in = bsel ? sximm5 : b_reg; // address offset

	alu_shift alu_i (.a_in(a_in), .b_in(b_in), .shift(shift), .alu_op(alu_op),
		.result(alu_out), .z(alu_z), .n(alu_n), .v(alu_v));
endmodule

// File: alu_shift.sv
// shifter and alu
`timescale 1ns/10ps

module alu_shift (
	input logic [cpu_pkg::word_width-1:0] a_in,
	input logic [cpu_pkg::word_width-1:0] b_in,
	input cpu_pkg::shift_t shift,
	input cpu_pkg::alu_op_t alu_op,
	output logic [cpu_pkg::word_width-1:0] result,
	output logic z,
	output logic n,
	output logic v
);
	localparam int msb = cpu_pkg::word_width - 1;

	logic [msb:0] b_sh;
	logic [msb:0] diff;

	always_comb begin
		case (shift)
			cpu_pkg::shift_lsl: b_sh = {b_in[msb-1:0], 1'b0};
			cpu_pkg::shift_lsr: b_sh = {1'b0, b_in[msb:1]};
			cpu_pkg::shift_asr: b_sh = {b_in[msb], b_in[msb:1]}; // keep sign
			default: b_sh = b_in;
		endcase
	end

	assign diff = a_in - b_sh;

	always_comb begin
		case (alu_op)
			cpu_pkg::alu_add: result = a_in + b_sh;
			cpu_pkg::alu_sub: result = diff;
			cpu_pkg::alu_and: result = a_in & b_sh;
			default: result = ~b_sh;
		endcase
	end

	assign z = (result == '0);
	assign n = result[msb];
	// signed overflow of a - b, only meaningful for cmp
	assign v = (a_in[msb] != b_sh[msb]) && (diff[msb] != a_in[msb]);
endmodule

// File: reg_file.sv
// general purpose register file
`timescale 1ns/10ps

module reg_file (
	input logic clk,
	input logic write,
	input logic [cpu_pkg::reg_sel_width-1:0] reg_num,
	input logic [cpu_pkg::word_width-1:0] data_in,
	output logic [cpu_pkg::word_width-1:0] data_out
);
	logic [cpu_pkg::word_width-1:0] regs [2**cpu_pkg::reg_sel_width];

	always_ff @(posedge clk) begin
		if (write) begin
			regs[reg_num] <= data_in;
		end
	end

	assign data_out = regs[reg_num]; // combinational read

	// the fsm must never write through an undecoded register field
	a_write_num_known: assert property (@(posedge clk) write |-> !$isunknown(reg_num))
		else $error("register write with unknown register number");
endmodule

// File: instr_decoder.sv
// instruction field decoder
`timescale 1ns/10ps

module instr_decoder (
	input logic [cpu_pkg::word_width-1:0] instr,
	input cpu_pkg::nsel_t nsel,
	output logic [2:0] opcode,
	output logic [2:0] cond,
	output logic [1:0] op,
	output cpu_pkg::shift_t shift,
	output logic [cpu_pkg::word_width-1:0] sximm5,
	output logic [cpu_pkg::word_width-1:0] sximm8,
	output logic [cpu_pkg::reg_sel_width-1:0] reg_num
);
	assign opcode = instr[15:13];
	assign op = instr[12:11];
	assign cond = instr[10:8]; // shares bits with rn

	// bits 4:3 belong to imm5 in ldr/str, so only register formats shift
	assign shift = (opcode == cpu_pkg::opc_mov || opcode == cpu_pkg::opc_alu) ?
		cpu_pkg::shift_t'(instr[4:3]) : cpu_pkg::shift_none;

	assign sximm5 = {{(cpu_pkg::word_width-5){instr[4]}}, instr[4:0]};
	assign sximm8 = {{(cpu_pkg::word_width-8){instr[7]}}, instr[7:0]};

	always_comb begin
		case (nsel)
			cpu_pkg::pick_rn: reg_num = instr[10:8];
			cpu_pkg::pick_rd: reg_num = instr[7:5];
			default: reg_num = instr[2:0]; // rm
		endcase
	end
endmodule

// File: cpu_pkg.sv
// cpu shared definitions
package cpu_pkg;

	localparam int word_width = 16;
	localparam int reg_sel_width = 3;

	// fetch states, then one state per execute step
	typedef enum logic [4:0] {
		reset_st, fetch1, fetch2, update_pc, decode_st,
		movi_s1,
		movs_s1, movs_s2, movs_s3, // mov shifted and mvn
		add_s1, add_s2, add_s3, add_s4, // add and and
		cmp_s1, cmp_s2, cmp_s3,
		ldr_s1, ldr_s2, ldr_s3, ldr_s4, ldr_s5,
		str_s1, str_s2, str_s3, str_s4, str_s5, str_s6,
		branch_s1,
		halt_st
	} state_t;

	typedef enum logic [1:0] {mem_none = 2'b00, mem_read = 2'b01, mem_write = 2'b10} mem_cmd_t;

	// encoding matches the op field of alu instructions
	typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_not_b} alu_op_t;

	typedef enum logic [1:0] {shift_none, shift_lsl, shift_lsr, shift_asr} shift_t;

	typedef enum logic [1:0] {from_c, from_imm8, from_mem} wb_src_t;

	typedef enum logic [2:0] {pick_rm = 3'b001, pick_rd = 3'b010, pick_rn = 3'b100} nsel_t;

	localparam logic [2:0] opc_branch = 3'b001;
	localparam logic [2:0] opc_ldr = 3'b011;
	localparam logic [2:0] opc_str = 3'b100;
	localparam logic [2:0] opc_alu = 3'b101;
	localparam logic [2:0] opc_mov = 3'b110;
	localparam logic [2:0] opc_halt = 3'b111;

	localparam logic [2:0] cond_al = 3'b000;
	localparam logic [2:0] cond_eq = 3'b001;
	localparam logic [2:0] cond_ne = 3'b010;
	localparam logic [2:0] cond_lt = 3'b011;
	localparam logic [2:0] cond_le = 3'b100;

endpackage
